//--- include/arb_cfg.svh
// ----------------------------
// Result arbiter configuration
// Tile count, widths, FIFO depth and
// output credit budget for the collector
// ----------------------------
`ifndef ARB_CFG_SVH
`define ARB_CFG_SVH

// Number of compute tiles feeding the arbiter
`define ARB_NUM_TILES 4

// FP16 result width
`define ARB_DATA_W 16

// Width of the B and C dimensions of a command
`define ARB_DIM_W 8

// Entries in each per-tile result FIFO
`define ARB_FIFO_DEPTH 16

// Credits granted by the sink after reset
`define ARB_OUT_CREDITS 4

`endif

//--- hw/arb_pkg.sv
// ----------------------------
// Result arbiter types
// Vector typedefs shared by the collector
// blocks and the FSM state encoding
// ----------------------------
`include "arb_cfg.svh"

package arb_pkg;

    // One FP16 result word
    typedef logic [`ARB_DATA_W-1:0] data_t;

    // B or C dimension of a command
    typedef logic [`ARB_DIM_W-1:0] dim_t;

    // Results per tile, B x C, needs twice the dimension width
    typedef logic [2*`ARB_DIM_W-1:0] count_t;

    // Tile index and tile enable mask
    typedef logic [$clog2(`ARB_NUM_TILES)-1:0] tile_idx_t;
    typedef logic [`ARB_NUM_TILES-1:0] tile_mask_t;

    // Occupancy 0..depth, so one extra bit over the pointer width
    typedef logic [$clog2(`ARB_FIFO_DEPTH):0] fifo_cnt_t;

    // Output credits 0..ARB_OUT_CREDITS
    typedef logic [$clog2(`ARB_OUT_CREDITS):0] credit_t;

    // Collection FSM
    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_COLLECT,
        ARB_DRAIN
    } arb_state_t;

endpackage

//--- hw/arb_cmd_if.sv
// ----------------------------
// Command link, decoder to scheduler
// Carries the captured job and the busy flag
// ----------------------------
`timescale 1ns/100ps

interface arb_cmd_if;
    import arb_pkg::*;

    // One-cycle pulse that opens a job
    logic       start;
    // Job parameters, stable from start until the next start
    tile_mask_t tile_en;
    dim_t       c_len;
    count_t     results_per_tile;
    // High from the cycle after start until the last result leaves
    logic       busy;

    // Decoder side
    modport src (
        output start, tile_en, c_len, results_per_tile,
        input  busy
    );

    // Scheduler side
    modport dst (
        input  start, tile_en, c_len, results_per_tile,
        output busy
    );

endinterface

//--- hw/arb_cmd_decode.sv
// ----------------------------
// Command decoder
// Accepts a job while the collector is idle,
// computes B x C and holds the job fields
// ----------------------------
`timescale 1ns/100ps

module arb_cmd_decode (
    input  logic                i_clk,
    input  logic                i_reset_n,
    input  logic                i_cmd_valid,
    input  arb_pkg::tile_mask_t i_cmd_tile_en,
    input  arb_pkg::dim_t       i_cmd_b_len,
    input  arb_pkg::dim_t       i_cmd_c_len,
    output logic                o_cmd_ready,
    arb_cmd_if.src              cmd
);
    import arb_pkg::*;

    logic cmd_accept;

    // Busy only rises the cycle after start, so start itself also blocks
    assign o_cmd_ready = ~cmd.busy & ~cmd.start;
    assign cmd_accept  = i_cmd_valid & o_cmd_ready;

    // Start pulse, one cycle after acceptance
    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            cmd.start <= 1'b0;
        end else begin
            cmd.start <= cmd_accept;
        end
    end

    // Job fields
    always_ff @(posedge i_clk) begin
        if (cmd_accept) begin
            cmd.tile_en <= i_cmd_tile_en;
            cmd.c_len   <= i_cmd_c_len;
            // Widen first so the product keeps all bits
            cmd.results_per_tile <= count_t'(i_cmd_b_len) * count_t'(i_cmd_c_len);
        end
    end

    // ----------------------------
    // Checks
    // ----------------------------

    // A job with no tile enabled would never produce output
    a_mask_nonzero : assert property (@(posedge i_clk) disable iff (!i_reset_n)
        cmd_accept |-> (|i_cmd_tile_en))
        else $error("command accepted with empty tile mask");

    // Scheduler must answer every start with busy on the next cycle
    a_start_busy : assert property (@(posedge i_clk) disable iff (!i_reset_n)
        cmd.start |=> cmd.busy)
        else $error("scheduler did not raise busy after start");

endmodule

//--- hw/tile_result_fifo.sv
// ----------------------------
// Per-tile result FIFO
// Circular buffer with a two-stage registered
// read path, same latency as a block RAM
// ----------------------------
`timescale 1ns/100ps
`include "arb_cfg.svh"

module tile_result_fifo #(
    parameter int depth = `ARB_FIFO_DEPTH
) (
    input  logic           i_clk,
    input  logic           i_reset_n,
    input  logic           i_push,
    input  arb_pkg::data_t i_push_data,
    input  logic           i_pop,
    output arb_pkg::data_t o_rd_data
);
    import arb_pkg::*;

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;

    data_t              mem [depth];
    logic [ptr_w-1:0]   wr_ptr;
    logic [ptr_w-1:0]   rd_ptr;
    logic [ptr_w:0]     count;
    logic               full;
    logic               empty;
    logic               wr_en;
    logic               rd_en;
    // First read stage, the array output latch
    data_t              rd_stage;

    assign full  = (count == (ptr_w + 1)'(depth));
    assign empty = (count == '0);
    // Overflowing pushes and empty pops are dropped
    assign wr_en = i_push & ~full;
    assign rd_en = i_pop & ~empty;

    // Pointers and occupancy
    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + (ptr_w + 1)'(wr_en) - (ptr_w + 1)'(rd_en);
        end
    end

    // Storage, no reset
    always_ff @(posedge i_clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= i_push_data;
        end
    end

    // Two-cycle read, pop in cycle N gives data in N+2
    always_ff @(posedge i_clk) begin
        if (rd_en) begin
            rd_stage <= mem[rd_ptr];
        end
        o_rd_data <= rd_stage;
    end

    // ----------------------------
    // Checks
    // ----------------------------

    // Compute engine ran more than depth ahead of the scheduler
    a_no_overflow : assert property (@(posedge i_clk) disable iff (!i_reset_n)
        i_push |-> !full)
        else $error("tile FIFO push while full");

    // Shadow count in the scheduler must never let a pop overtake a push
    a_no_underflow : assert property (@(posedge i_clk) disable iff (!i_reset_n)
        i_pop |-> !empty)
        else $error("tile FIFO pop while empty");

endmodule

//--- hw/arb_rr_scheduler.sv
// ----------------------------
// Round-robin collection scheduler
// Reads C results per visit from each enabled
// tile, tracks shadow occupancy and credits
// ----------------------------
`timescale 1ns/100ps
`include "arb_cfg.svh"

module arb_rr_scheduler (
    input  logic                i_clk,
    input  logic                i_reset_n,
    arb_cmd_if.dst              cmd,
    input  arb_pkg::tile_mask_t i_ce_valid,
    input  logic                i_result_credit,
    input  logic                i_out_valid,
    output arb_pkg::tile_mask_t o_pop,
    output logic                o_issue_valid,
    output arb_pkg::tile_idx_t  o_issue_tile
);
    import arb_pkg::*;

    localparam int num_tiles = `ARB_NUM_TILES;

    arb_state_t state;
    tile_idx_t  cur_tile;
    dim_t       chunk_cnt;
    credit_t    credits;
    // Pops not yet seen on the output register
    credit_t    outstanding;
    credit_t    outstanding_next;
    fifo_cnt_t  shadow_cnt [num_tiles];
    count_t     result_cnt [num_tiles];

    logic       active;
    logic       cur_en;
    logic       cur_done;
    logic       chunk_full;
    logic       pop_now;
    logic       last_of_chunk;
    logic       last_of_tile;
    logic       move;
    logic       all_done;
    tile_mask_t tile_done;
    tile_mask_t scan_done;
    tile_idx_t  next_tile;

    // Issue decisions are also made in the start cycle, counters are already
    // zero there because reset and the end of a job leave them cleared
    assign active = (state == ARB_COLLECT) || (state == ARB_IDLE && cmd.start);

    assign cur_en     = cmd.tile_en[cur_tile];
    assign cur_done   = tile_done[cur_tile];
    assign chunk_full = (chunk_cnt >= cmd.c_len);

    // Read only when data is there, the chunk and tile have room and a credit is left
    assign pop_now = active && cur_en && !cur_done && !chunk_full &&
                     (shadow_cnt[cur_tile] != '0) && (credits != '0);

    assign last_of_chunk = (dim_t'(chunk_cnt + 1'b1) == cmd.c_len);
    assign last_of_tile  = (count_t'(result_cnt[cur_tile] + 1'b1) == cmd.results_per_tile);

    // Leave a disabled or finished tile, or one whose chunk just closed
    assign move = active &&
                  (!cur_en || cur_done || chunk_full ||
                   (pop_now && (last_of_chunk || last_of_tile)));

    assign outstanding_next = outstanding + credit_t'(pop_now) - credit_t'(i_out_valid);

    // ----------------------------
    // Tile status and next tile
    // ----------------------------
    always_comb begin
        for (int i = 0; i < num_tiles; i++) begin
            tile_done[i] = (result_cnt[i] >= cmd.results_per_tile);
        end
        // Current tile counts as finished once its last read goes out
        scan_done = tile_done;
        if (pop_now && last_of_tile) begin
            scan_done[cur_tile] = 1'b1;
        end
        all_done = 1'b1;
        for (int i = 0; i < num_tiles; i++) begin
            if (cmd.tile_en[i] && !tile_done[i]) begin
                all_done = 1'b0;
            end
        end
    end

    // First enabled unfinished tile above the current one, wrapping around
    always_comb begin : next_scan
        tile_idx_t idx;
        logic      found;
        idx       = cur_tile;
        found     = 1'b0;
        next_tile = cur_tile;
        for (int i = 0; i < num_tiles; i++) begin
            idx = (idx == tile_idx_t'(num_tiles - 1)) ? '0 : idx + 1'b1;
            if (!found && cmd.tile_en[idx] && !scan_done[idx]) begin
                next_tile = idx;
                found     = 1'b1;
            end
        end
    end

    // ----------------------------
    // FSM and counters
    // ----------------------------
    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            state         <= ARB_IDLE;
            cmd.busy      <= 1'b0;
            cur_tile      <= '0;
            chunk_cnt     <= '0;
            credits       <= credit_t'(`ARB_OUT_CREDITS);
            outstanding   <= '0;
            o_pop         <= '0;
            o_issue_valid <= 1'b0;
            for (int i = 0; i < num_tiles; i++) begin
                shadow_cnt[i] <= '0;
                result_cnt[i] <= '0;
            end
        end else begin
            // One credit per pop, one back per sink pulse
            credits     <= credits - credit_t'(pop_now) + credit_t'(i_result_credit);
            outstanding <= outstanding_next;

            // Registered pop, at most one tile
            o_pop         <= tile_mask_t'(pop_now) << cur_tile;
            o_issue_valid <= pop_now;

            // Shadow occupancy follows the FIFO without its read latency
            for (int i = 0; i < num_tiles; i++) begin
                shadow_cnt[i] <= shadow_cnt[i] + fifo_cnt_t'(i_ce_valid[i])
                               - fifo_cnt_t'(pop_now && (cur_tile == tile_idx_t'(i)));
            end
            if (pop_now) begin
                result_cnt[cur_tile] <= result_cnt[cur_tile] + 1'b1;
            end

            // Round-robin pointer and chunk position
            if (move) begin
                cur_tile  <= next_tile;
                chunk_cnt <= '0;
            end else if (pop_now) begin
                chunk_cnt <= chunk_cnt + 1'b1;
            end

            case (state)
                ARB_IDLE: begin
                    if (cmd.start) begin
                        state    <= ARB_COLLECT;
                        cmd.busy <= 1'b1;
                    end
                end
                ARB_COLLECT: begin
                    if (all_done) begin
                        state <= ARB_DRAIN;
                    end
                end
                ARB_DRAIN: begin
                    // Wait for the pipe to empty, then clear for the next job
                    if (outstanding_next == '0) begin
                        state     <= ARB_IDLE;
                        cmd.busy  <= 1'b0;
                        cur_tile  <= '0;
                        chunk_cnt <= '0;
                        for (int i = 0; i < num_tiles; i++) begin
                            result_cnt[i] <= '0;
                        end
                    end
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    // Tile tag for the result pipe
    always_ff @(posedge i_clk) begin
        o_issue_tile <= cur_tile;
    end

    // ----------------------------
    // Checks
    // ----------------------------
    a_pop_onehot : assert property (@(posedge i_clk) disable iff (!i_reset_n)
        $onehot0(o_pop))
        else $error("more than one tile popped in a cycle");

    // Sink returned a credit it was never given
    a_credit_bound : assert property (@(posedge i_clk) disable iff (!i_reset_n)
        (i_result_credit && !pop_now) |-> (credits < credit_t'(`ARB_OUT_CREDITS)))
        else $error("credit returned beyond the granted budget");

endmodule

//--- hw/arb_result_pipe.sv
// ----------------------------
// Result pipe
// Carries the tile tag across the FIFO read
// latency, selects and registers the output
// ----------------------------
`timescale 1ns/100ps
`include "arb_cfg.svh"

module arb_result_pipe (
    input  logic               i_clk,
    input  logic               i_reset_n,
    input  logic               i_issue_valid,
    input  arb_pkg::tile_idx_t i_issue_tile,
    input  arb_pkg::data_t     i_fifo_rd_data [`ARB_NUM_TILES],
    output logic               o_result_valid,
    output arb_pkg::data_t     o_result_data
);
    import arb_pkg::*;

    // Stage one lines up with the FIFO array read
    logic      valid_s1;
    tile_idx_t tile_s1;
    // Stage two lines up with the FIFO output register
    logic      valid_s2;
    tile_idx_t tile_s2;

    // Valid flags
    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            valid_s1       <= 1'b0;
            valid_s2       <= 1'b0;
            o_result_valid <= 1'b0;
        end else begin
            valid_s1       <= i_issue_valid;
            valid_s2       <= valid_s1;
            // Pop plus three
            o_result_valid <= valid_s2;
        end
    end

    // Tile tags and output data
    always_ff @(posedge i_clk) begin
        tile_s1 <= i_issue_tile;
        tile_s2 <= tile_s1;
        // FIFO data is valid now, so stage two picks the source
        o_result_data <= i_fifo_rd_data[tile_s2];
    end

endmodule

//--- hw/arb_top.sv
// ----------------------------
// Result arbiter top level
// Decoder, per-tile FIFOs, scheduler and
// result pipe on plain ports
// ----------------------------
`timescale 1ns/100ps
`include "arb_cfg.svh"

module arb_top (
    input  logic                i_clk,
    input  logic                i_reset_n,
    input  logic                i_cmd_valid,
    output logic                o_cmd_ready,
    input  arb_pkg::tile_mask_t i_cmd_tile_en,
    input  arb_pkg::dim_t       i_cmd_b_len,
    input  arb_pkg::dim_t       i_cmd_c_len,
    input  arb_pkg::tile_mask_t i_ce_valid,
    input  arb_pkg::data_t      i_ce_data [`ARB_NUM_TILES],
    output logic                o_result_valid,
    output arb_pkg::data_t      o_result_data,
    input  logic                i_result_credit,
    output logic                o_busy
);
    import arb_pkg::*;

    tile_mask_t tile_pop;
    data_t      fifo_rd_data [`ARB_NUM_TILES];
    logic       issue_valid;
    tile_idx_t  issue_tile;

    // Command link between decoder and scheduler
    arb_cmd_if cmd_bus ();

    assign o_busy = cmd_bus.busy;

    arb_cmd_decode u_decode (
        .i_clk         (i_clk),
        .i_reset_n     (i_reset_n),
        .i_cmd_valid   (i_cmd_valid),
        .i_cmd_tile_en (i_cmd_tile_en),
        .i_cmd_b_len   (i_cmd_b_len),
        .i_cmd_c_len   (i_cmd_c_len),
        .o_cmd_ready   (o_cmd_ready),
        .cmd           (cmd_bus.src)
    );

    // One result FIFO per tile, written by its compute engine
    for (genvar g = 0; g < `ARB_NUM_TILES; g++) begin : g_tile
        tile_result_fifo #(
            .depth (`ARB_FIFO_DEPTH)
        ) u_fifo (
            .i_clk       (i_clk),
            .i_reset_n   (i_reset_n),
            .i_push      (i_ce_valid[g]),
            .i_push_data (i_ce_data[g]),
            .i_pop       (tile_pop[g]),
            .o_rd_data   (fifo_rd_data[g])
        );
    end

    arb_rr_scheduler u_sched (
        .i_clk           (i_clk),
        .i_reset_n       (i_reset_n),
        .cmd             (cmd_bus.dst),
        .i_ce_valid      (i_ce_valid),
        .i_result_credit (i_result_credit),
        .i_out_valid     (o_result_valid),
        .o_pop           (tile_pop),
        .o_issue_valid   (issue_valid),
        .o_issue_tile    (issue_tile)
    );

    arb_result_pipe u_pipe (
        .i_clk          (i_clk),
        .i_reset_n      (i_reset_n),
        .i_issue_valid  (issue_valid),
        .i_issue_tile   (issue_tile),
        .i_fifo_rd_data (fifo_rd_data),
        .o_result_valid (o_result_valid),
        .o_result_data  (o_result_data)
    );

endmodule

//--- sim/arb_tb.sv
// ------------------------------
// Result arbiter testbench
// Table-driven jobs with compute engine and
// credit sink models, checks chunked order
// ------------------------------
`timescale 1ns/100ps
`include "arb_cfg.svh"

module arb_tb;
    import arb_pkg::*;

    localparam int num_tiles = `ARB_NUM_TILES;
    localparam int num_rows  = 6;
    localparam int depth     = `ARB_FIFO_DEPTH;

    logic       i_clk;
    logic       i_reset_n;
    logic       i_cmd_valid;
    logic       o_cmd_ready;
    tile_mask_t i_cmd_tile_en;
    dim_t       i_cmd_b_len;
    dim_t       i_cmd_c_len;
    tile_mask_t i_ce_valid;
    data_t      i_ce_data [num_tiles];
    logic       o_result_valid;
    data_t      o_result_data;
    logic       i_result_credit;
    logic       o_busy;

    // Command table with one job per row
    tile_mask_t  tbl_mask  [num_rows];
    dim_t        tbl_b     [num_rows];
    dim_t        tbl_c     [num_rows];
    // Write gap limit per tile in one nibble each with tile 0 lowest
    logic [31:0] tbl_gaps  [num_rows];
    int          tbl_delay [num_rows];
    logic        table_ready;

    // Compute engine state for the running job
    tile_mask_t job_mask;
    int         job_total;
    int         job_delay;
    int         ce_written [num_tiles];
    int         ce_wait    [num_tiles];
    int         ce_gap     [num_tiles];
    int         rcv_cnt    [num_tiles];

    // Expected stream, credit return times and counters
    data_t      exp_q [$];
    int         credit_due_q [$];
    int         cycle;
    int         delivered;
    int         returned;
    int         error_count;
    integer     seed;

    // 20 ns clock
    initial begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    arb_top dut0 (
        .i_clk           (i_clk),
        .i_reset_n       (i_reset_n),
        .i_cmd_valid     (i_cmd_valid),
        .o_cmd_ready     (o_cmd_ready),
        .i_cmd_tile_en   (i_cmd_tile_en),
        .i_cmd_b_len     (i_cmd_b_len),
        .i_cmd_c_len     (i_cmd_c_len),
        .i_ce_valid      (i_ce_valid),
        .i_ce_data       (i_ce_data),
        .o_result_valid  (o_result_valid),
        .o_result_data   (o_result_data),
        .i_result_credit (i_result_credit),
        .o_busy          (o_busy)
    );

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            error_count++;
            $display("Fail: %s expected 0x%h, got 0x%h", name, expected, actual);
            $display("Verification failed");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic stop_run(input string reason);
        error_count++;
        $display("%s", reason);
        $display("Verification failed");
        $fatal(1, "%s", reason);
    endtask

    task automatic set_row(input int row, input tile_mask_t mask, input int b, input int c,
                           input logic [31:0] gaps, input int delay);
        tbl_mask[row]  = mask;
        tbl_b[row]     = dim_t'(b);
        tbl_c[row]     = dim_t'(c);
        tbl_gaps[row]  = gaps;
        tbl_delay[row] = delay;
    endtask

    task automatic load_table();
        // Single tile with credits returned at once
        set_row(0, 'b0001, 3, 4, 32'h0000, 0);
        // All tiles with uneven write rates
        set_row(1, 'b1111, 4, 3, 32'h1520, 1);
        // Hole at tile 2
        set_row(2, 'b1011, 2, 5, 32'h2003, 2);
        // Credits held back long enough to stall pops
        set_row(3, 'b0110, 3, 2, 32'h0010, 25);
        set_row(4, 'b1101, 2, 7, 32'h0401, 0);
        // Top tile only with a chunk of one
        set_row(5, 'b1000, 5, 1, 32'h3000, 3);
    endtask

    // Chunked round robin takes C values from each enabled tile per row of B
    task automatic build_expected(input int row);
        int next_idx [num_tiles];
        for (int t = 0; t < num_tiles; t++) begin
            next_idx[t] = 0;
        end
        for (int r = 0; r < int'(tbl_b[row]); r++) begin
            for (int t = 0; t < num_tiles; t++) begin
                if (tbl_mask[row][t]) begin
                    for (int k = 0; k < int'(tbl_c[row]); k++) begin
                        exp_q.push_back(data_t'(t * 4096 + next_idx[t]));
                        next_idx[t]++;
                    end
                end
            end
        end
    endtask

    // Loaded mid cycle away from the models and the monitor
    task automatic start_job(input int row);
        @(negedge i_clk);
        #1;
        job_mask  = tbl_mask[row];
        job_total = int'(tbl_b[row]) * int'(tbl_c[row]);
        job_delay = tbl_delay[row];
        for (int t = 0; t < num_tiles; t++) begin
            ce_written[t] = 0;
            ce_wait[t]    = 0;
            rcv_cnt[t]    = 0;
            ce_gap[t]     = int'((tbl_gaps[row] >> (4 * t)) & 32'hF);
        end
        build_expected(row);
    endtask

    task automatic issue_command(input int row);
        @(posedge i_clk);
        #1;
        i_cmd_valid   = 1'b1;
        i_cmd_tile_en = tbl_mask[row];
        i_cmd_b_len   = tbl_b[row];
        i_cmd_c_len   = tbl_c[row];
        // Ready only depends on registers, so it is stable here
        while (o_cmd_ready !== 1'b1) begin
            @(posedge i_clk);
            #1;
        end
        @(posedge i_clk);
        #1;
        i_cmd_valid = 1'b0;
    endtask

    task automatic wait_job_end();
        while (o_busy !== 1'b1) begin
            @(posedge i_clk);
            #1;
        end
        while (o_busy !== 1'b0) begin
            @(posedge i_clk);
            #1;
        end
    endtask

    task automatic check_job();
        check_value("pending results", 0, exp_q.size());
    endtask

    // ------------------------------
    // Compute engine and sink models
    // ------------------------------
    initial begin : drive_models
        wait (table_ready === 1'b1);
        forever begin
            @(posedge i_clk);
            #1;
            cycle++;
            // One credit pulse per cycle at most
            i_result_credit = 1'b0;
            if (credit_due_q.size() > 0 && credit_due_q[0] <= cycle) begin
                void'(credit_due_q.pop_front());
                i_result_credit = 1'b1;
                returned++;
            end
            i_ce_valid = '0;
            for (int t = 0; t < num_tiles; t++) begin
                // Stay within FIFO depth of what has come out
                if (job_mask[t] && ce_written[t] < job_total &&
                    ce_written[t] - rcv_cnt[t] < depth) begin
                    if (ce_wait[t] == 0) begin
                        i_ce_valid[t] = 1'b1;
                        i_ce_data[t]  = data_t'(t * 4096 + ce_written[t]);
                        ce_written[t]++;
                        ce_wait[t] = $unsigned($random(seed)) % (ce_gap[t] + 1);
                    end else begin
                        ce_wait[t]--;
                    end
                end
            end
        end
    end

    // Output monitor sampled mid cycle
    always @(negedge i_clk) begin : monitor
        int tile_of;
        if (i_reset_n === 1'b1) begin
            if (o_busy === 1'b1) begin
                check_value("o_cmd_ready", 0, o_cmd_ready);
            end
            if (o_result_valid === 1'b1) begin
                if (exp_q.size() == 0) begin
                    stop_run("A result came out while none was expected");
                end else begin
                    check_value("o_result_data", exp_q[0], o_result_data);
                    tile_of = int'(exp_q[0]) / 4096;
                    rcv_cnt[tile_of]++;
                    void'(exp_q.pop_front());
                    delivered++;
                    // Never more out than granted plus returned credits
                    if (delivered > `ARB_OUT_CREDITS + returned) begin
                        stop_run("More results came out than the output credits allow");
                    end
                    credit_due_q.push_back(cycle + job_delay);
                end
            end
        end
    end

    // Watchdog sized from the total result count
    initial begin : watchdog
        int total;
        int max_delay;
        int limit;
        wait (table_ready === 1'b1);
        total     = 0;
        max_delay = 0;
        for (int r = 0; r < num_rows; r++) begin
            total += int'(tbl_b[r]) * int'(tbl_c[r]) * $countones(tbl_mask[r]);
            if (tbl_delay[r] > max_delay) begin
                max_delay = tbl_delay[r];
            end
        end
        limit = (total + 10 * num_rows) * (16 + max_delay) * 2;
        repeat (limit) @(posedge i_clk);
        $display("Watchdog expired after %0d cycles with jobs still running", limit);
        $display("Verification failed");
        $fatal(1, "Timeout");
    end

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin : main
        table_ready     = 1'b0;
        seed            = 51;
        i_reset_n       = 1'b0;
        i_cmd_valid     = 1'b0;
        i_cmd_tile_en   = '0;
        i_cmd_b_len     = '0;
        i_cmd_c_len     = '0;
        i_ce_valid      = '0;
        i_result_credit = 1'b0;
        job_mask        = '0;
        job_total       = 0;
        job_delay       = 0;
        cycle           = 0;
        delivered       = 0;
        returned        = 0;
        error_count     = 0;
        for (int t = 0; t < num_tiles; t++) begin
            i_ce_data[t]  = '0;
            ce_written[t] = 0;
            ce_wait[t]    = 0;
            ce_gap[t]     = 0;
            rcv_cnt[t]    = 0;
        end
        load_table();
        table_ready = 1'b1;

        repeat (2) @(posedge i_clk);
        #1;
        i_reset_n = 1'b1;

        // Idle after reset
        @(negedge i_clk);
        check_value("o_busy", 0, o_busy);
        check_value("o_result_valid", 0, o_result_valid);
        check_value("o_cmd_ready", 1, o_cmd_ready);

        // Rows run back to back and each one waits for busy to fall
        for (int row = 0; row < num_rows; row++) begin
            start_job(row);
            issue_command(row);
            wait_job_end();
            check_job();
        end

        if (error_count == 0) begin
            $display("Verification passed");
            $finish;
        end else begin
            $display("Verification failed");
            $fatal(1, "Errors found");
        end
    end

endmodule

//--- src.f
+incdir+include
hw/arb_pkg.sv
hw/arb_cmd_if.sv
hw/arb_cmd_decode.sv
hw/tile_result_fifo.sv
hw/arb_rr_scheduler.sv
hw/arb_result_pipe.sv
hw/arb_top.sv
sim/arb_tb.sv

//--- Makefile
# Verilator flow for the result arbiter
# Every variable can be overridden on the command line

VERILATOR  ?= verilator
TB_TOP     ?= arb_tb
RTL_TOP    ?= arb_top
FILELIST   ?= src.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
FAIL_MSG   ?= Verification failed
PASS_MSG   ?= Verification passed
SIM_FLAGS  ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only -Wall --timing

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(BUILD_DIR)

sim: build
	-./$(BUILD_DIR)/V$(TB_TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation reported a failure, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
